/* rtl/retire_defines.svh */
`ifndef RETIRE_DEFINES_SVH
`define RETIRE_DEFINES_SVH

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// datapath sizes.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`define RETIRE_XLEN        32
`define RETIRE_NREGS       32
`define RETIRE_REG_RESET   32'hffff_ffff

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// debug register byte offsets.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`define RETIRE_CSR_CTRL        8'h00
`define RETIRE_CSR_LIMIT_LO    8'h04
`define RETIRE_CSR_LIMIT_HI    8'h08
`define RETIRE_CSR_STATUS      8'h0c
`define RETIRE_CSR_CYCLE_LO    8'h10
`define RETIRE_CSR_CYCLE_HI    8'h14
`define RETIRE_CSR_INSTRET_LO  8'h18
`define RETIRE_CSR_INSTRET_HI  8'h1c
`define RETIRE_CSR_REGS        8'h80

`endif

/* rtl/retire_pkg.sv */
`default_nettype none

`include "retire_defines.svh"

package retire_pkg;

    // one register file word.
    typedef logic [`RETIRE_XLEN-1:0] xlen_t;

    // program counter of a retiring instruction.
    typedef logic [`RETIRE_XLEN-1:0] addr_t;

    // raw instruction word, always 32 bits in RV32.
    typedef logic [31:0] inst_t;

    // tag handed out at issue.
    typedef logic [7:0] iid_t;

    // register index, x0..x31.
    typedef logic [4:0] reg_idx_t;

    // wide event counters.
    typedef logic [63:0] count_t;

endpackage

`default_nettype wire

/* rtl/retire_if.sv */
`timescale 1ns/1ps
`default_nettype none

interface retire_if;
    import retire_pkg::*;

    logic     valid;
    addr_t    pc;
    inst_t    inst;
    iid_t     inst_id;
    logic     rf_wen;
    reg_idx_t reg_addr;
    xlen_t    wdata;

    // the producer side of the retire record.
    modport src (
        output valid, pc, inst, inst_id, rf_wen, reg_addr, wdata
    );

    // the write-back side, no back-pressure.
    modport sink (
        input valid, pc, inst, inst_id, rf_wen, reg_addr, wdata
    );

endinterface

`default_nettype wire

/* rtl/write_back_stage.sv */
`timescale 1ns/1ps
`default_nettype none

`include "retire_defines.svh"

module write_back_stage (
    input  wire logic              clk,
    input  wire logic              rst_n,
    retire_if.sink                 ret,
    input  wire logic              halted,
    output logic                   commit,
    input  wire retire_pkg::reg_idx_t rs1_addr,
    input  wire retire_pkg::reg_idx_t rs2_addr,
    output retire_pkg::xlen_t      rs1_data,
    output retire_pkg::xlen_t      rs2_data,
    input  wire retire_pkg::reg_idx_t dbg_addr,
    output retire_pkg::xlen_t      dbg_data
);
    import retire_pkg::*;

    logic  wen;
    xlen_t rf_q [`RETIRE_NREGS];

    // a record retires unless the counters have stopped the core.
    assign commit = ret.valid && !halted;
    assign wen    = commit && ret.rf_wen && (ret.reg_addr != '0);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // register file.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // entry 0 is loaded with zero at reset and never written again.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rf_q[0] <= '0;
            for (int i = 1; i < `RETIRE_NREGS; i++) begin
                rf_q[i] <= `RETIRE_REG_RESET;
            end
        end else if (wen) begin
            rf_q[ret.reg_addr] <= ret.wdata;
        end
    end

    // decode ports see the word being committed this cycle.
    always_comb begin
        rs1_data = rf_q[rs1_addr];
        if (wen && (rs1_addr == ret.reg_addr)) begin
            rs1_data = ret.wdata;
        end
        rs2_data = rf_q[rs2_addr];
        if (wen && (rs2_addr == ret.reg_addr)) begin
            rs2_data = ret.wdata;
        end
    end

    // debugger sees stored state only.
    assign dbg_data = rf_q[dbg_addr];

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // checks.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // write data must be known whenever a register is written.
    a_wdata_known: assert property (
        @(posedge clk) disable iff (!rst_n)
        commit && ret.rf_wen |-> !$isunknown(ret.wdata)
    ) else $error("wdata %h unknown at pc %h inst %h id %h",
                  ret.wdata, ret.pc, ret.inst, ret.inst_id);

    a_addr_known: assert property (
        @(posedge clk) disable iff (!rst_n)
        ret.valid |-> !$isunknown(ret.reg_addr)
    ) else $error("reg_addr unknown at pc %h", ret.pc);

endmodule

`default_nettype wire

/* rtl/retire_counters.sv */
`timescale 1ns/1ps
`default_nettype none

module retire_counters (
    input  wire logic               clk,
    input  wire logic               rst_n,
    input  wire logic               commit,
    input  wire logic               clear_cnt,
    input  wire logic               limit_en,
    input  wire retire_pkg::count_t limit,
    output retire_pkg::count_t      cycle_cnt,
    output retire_pkg::count_t      instret_cnt,
    output logic                    halted
);
    import retire_pkg::*;

    count_t cycle_q;
    count_t instret_q;
    count_t instret_nxt;
    logic   halted_q;
    logic   limit_hit;

    assign instret_nxt = instret_q + 64'd1;

    // compare against the value the counter is about to take.
    assign limit_hit = commit && limit_en && (instret_nxt == limit);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // counters and halt flag.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cycle_q   <= '0;
            instret_q <= '0;
            halted_q  <= 1'b0;
        end else if (clear_cnt) begin
            cycle_q   <= '0;
            instret_q <= '0;
            halted_q  <= 1'b0;
        end else begin
            cycle_q <= cycle_q + 64'd1;
            if (commit) begin
                instret_q <= instret_nxt;
            end
            // sticky until cleared.
            if (limit_hit) begin
                halted_q <= 1'b1;
            end
        end
    end

    assign cycle_cnt   = cycle_q;
    assign instret_cnt = instret_q;
    assign halted      = halted_q;

    // the write-back stage must stop committing once halted.
    a_halt_freezes_instret: assert property (
        @(posedge clk) disable iff (!rst_n)
        halted && !clear_cnt |=> $stable(instret_cnt)
    ) else $error("instret moved while halted, now %h", instret_cnt);

endmodule

`default_nettype wire

/* rtl/debug_csr.sv */
`timescale 1ns/1ps
`default_nettype none

`include "retire_defines.svh"

module debug_csr (
    input  wire logic                 clk,
    input  wire logic                 rst_n,
    input  wire logic                 wb_cyc,
    input  wire logic                 wb_stb,
    input  wire logic                 wb_we,
    input  wire retire_pkg::xlen_t    wb_adr,
    input  wire retire_pkg::xlen_t    wb_dat_w,
    input  wire logic [3:0]           wb_sel,
    output retire_pkg::xlen_t         wb_dat_r,
    output logic                      wb_ack,
    output logic                      limit_en,
    output logic                      clear_cnt,
    output retire_pkg::count_t        limit,
    input  wire logic                 halted,
    input  wire retire_pkg::count_t   cycle_cnt,
    input  wire retire_pkg::count_t   instret_cnt,
    output retire_pkg::reg_idx_t      dbg_addr,
    input  wire retire_pkg::xlen_t    dbg_data
);
    import retire_pkg::*;

    logic   req;
    logic   wr;
    logic   in_page;
    logic   in_window;
    xlen_t  rd_data;
    logic   ack_q;
    xlen_t  dat_r_q;
    logic   limit_en_q;
    logic   clear_q;
    count_t limit_q;

    // new request only while no ack is pending.
    assign req = wb_cyc && wb_stb && !ack_q;
    assign wr  = req && wb_we;

    assign in_page   = (wb_adr[`RETIRE_XLEN-1:8] == '0);
    assign in_window = in_page && (wb_adr[7:0] >= `RETIRE_CSR_REGS) && (wb_adr[1:0] == 2'b00);

    // word index into the register window.
    assign dbg_addr = wb_adr[6:2];

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // read mux.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_comb begin
        rd_data = '0;
        if (in_window) begin
            rd_data = dbg_data;
        end else if (in_page) begin
            case (wb_adr[7:0])
                `RETIRE_CSR_CTRL:       rd_data = xlen_t'(limit_en_q);
                `RETIRE_CSR_LIMIT_LO:   rd_data = limit_q[31:0];
                `RETIRE_CSR_LIMIT_HI:   rd_data = limit_q[63:32];
                `RETIRE_CSR_STATUS:     rd_data = xlen_t'(halted);
                `RETIRE_CSR_CYCLE_LO:   rd_data = cycle_cnt[31:0];
                `RETIRE_CSR_CYCLE_HI:   rd_data = cycle_cnt[63:32];
                `RETIRE_CSR_INSTRET_LO: rd_data = instret_cnt[31:0];
                `RETIRE_CSR_INSTRET_HI: rd_data = instret_cnt[63:32];
                default:                rd_data = '0;
            endcase
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // bus handshake and writable registers.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ack_q      <= 1'b0;
            clear_q    <= 1'b0;
            limit_en_q <= 1'b0;
            limit_q    <= '0;
        end else begin
            ack_q   <= req;
            // clear fires during the ack cycle, counters drop on the edge after.
            clear_q <= wr && in_page && (wb_adr[7:0] == `RETIRE_CSR_CTRL) && wb_dat_w[1];
            if (wr && in_page) begin
                case (wb_adr[7:0])
                    `RETIRE_CSR_CTRL:     limit_en_q     <= wb_dat_w[0];
                    `RETIRE_CSR_LIMIT_LO: limit_q[31:0]  <= wb_dat_w;
                    `RETIRE_CSR_LIMIT_HI: limit_q[63:32] <= wb_dat_w;
                    default: ;
                endcase
            end
        end
    end

    // read data is captured with the ack.
    always_ff @(posedge clk) begin
        if (req) begin
            dat_r_q <= rd_data;
        end
    end

    assign wb_ack    = ack_q;
    assign wb_dat_r  = dat_r_q;
    assign limit_en  = limit_en_q;
    assign limit     = limit_q;
    assign clear_cnt = clear_q;

    // only full-word writes are supported.
    a_full_word_write: assert property (
        @(posedge clk) disable iff (!rst_n)
        wb_cyc && wb_stb && wb_we |-> wb_sel == 4'hf
    ) else $error("partial write, wb_sel %h", wb_sel);

endmodule

`default_nettype wire

/* rtl/retire_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module retire_unit (
    input  wire logic                 clk,
    input  wire logic                 rst_n,
    // retire record.
    input  wire logic                 ret_valid,
    input  wire retire_pkg::addr_t    ret_pc,
    input  wire retire_pkg::inst_t    ret_inst,
    input  wire retire_pkg::iid_t     ret_inst_id,
    input  wire logic                 ret_rf_wen,
    input  wire retire_pkg::reg_idx_t ret_reg_addr,
    input  wire retire_pkg::xlen_t    ret_wdata,
    // decode read ports.
    input  wire retire_pkg::reg_idx_t rs1_addr,
    input  wire retire_pkg::reg_idx_t rs2_addr,
    output retire_pkg::xlen_t         rs1_data,
    output retire_pkg::xlen_t         rs2_data,
    // wishbone slave.
    input  wire logic                 wb_cyc,
    input  wire logic                 wb_stb,
    input  wire logic                 wb_we,
    input  wire retire_pkg::xlen_t    wb_adr,
    input  wire retire_pkg::xlen_t    wb_dat_w,
    input  wire logic [3:0]           wb_sel,
    output retire_pkg::xlen_t         wb_dat_r,
    output logic                      wb_ack,
    output logic                      halted
);
    import retire_pkg::*;

    logic     commit;
    logic     limit_en;
    logic     clear_cnt;
    count_t   limit;
    count_t   cycle_cnt;
    count_t   instret_cnt;
    reg_idx_t dbg_addr;
    xlen_t    dbg_data;

    retire_if ret_bus ();

    assign ret_bus.valid    = ret_valid;
    assign ret_bus.pc       = ret_pc;
    assign ret_bus.inst     = ret_inst;
    assign ret_bus.inst_id  = ret_inst_id;
    assign ret_bus.rf_wen   = ret_rf_wen;
    assign ret_bus.reg_addr = ret_reg_addr;
    assign ret_bus.wdata    = ret_wdata;

    write_back_stage write_back_stage_inst (
        .clk      (clk),
        .rst_n    (rst_n),
        .ret      (ret_bus.sink),
        .halted   (halted),
        .commit   (commit),
        .rs1_addr (rs1_addr),
        .rs2_addr (rs2_addr),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .dbg_addr (dbg_addr),
        .dbg_data (dbg_data)
    );

    retire_counters retire_counters_inst (
        .clk         (clk),
        .rst_n       (rst_n),
        .commit      (commit),
        .clear_cnt   (clear_cnt),
        .limit_en    (limit_en),
        .limit       (limit),
        .cycle_cnt   (cycle_cnt),
        .instret_cnt (instret_cnt),
        .halted      (halted)
    );

    debug_csr debug_csr_inst (
        .clk         (clk),
        .rst_n       (rst_n),
        .wb_cyc      (wb_cyc),
        .wb_stb      (wb_stb),
        .wb_we       (wb_we),
        .wb_adr      (wb_adr),
        .wb_dat_w    (wb_dat_w),
        .wb_sel      (wb_sel),
        .wb_dat_r    (wb_dat_r),
        .wb_ack      (wb_ack),
        .limit_en    (limit_en),
        .clear_cnt   (clear_cnt),
        .limit       (limit),
        .halted      (halted),
        .cycle_cnt   (cycle_cnt),
        .instret_cnt (instret_cnt),
        .dbg_addr    (dbg_addr),
        .dbg_data    (dbg_data)
    );

endmodule

`default_nettype wire

/* bench/tb_retire_unit.sv */
`timescale 1ns/1ps
`default_nettype none

`include "retire_defines.svh"

module tb_retire_unit;
    import retire_pkg::*;

    localparam int ack_timeout = 16;
    localparam int halt_limit  = 12;

    localparam logic [31:0] ctrl_adr       = 32'(`RETIRE_CSR_CTRL);
    localparam logic [31:0] limit_lo_adr   = 32'(`RETIRE_CSR_LIMIT_LO);
    localparam logic [31:0] limit_hi_adr   = 32'(`RETIRE_CSR_LIMIT_HI);
    localparam logic [31:0] status_adr     = 32'(`RETIRE_CSR_STATUS);
    localparam logic [31:0] cycle_lo_adr   = 32'(`RETIRE_CSR_CYCLE_LO);
    localparam logic [31:0] instret_lo_adr = 32'(`RETIRE_CSR_INSTRET_LO);
    localparam logic [31:0] regs_adr       = 32'(`RETIRE_CSR_REGS);

    logic        clk;
    logic        rst_n;
    logic        ret_valid;
    addr_t       ret_pc;
    inst_t       ret_inst;
    iid_t        ret_inst_id;
    logic        ret_rf_wen;
    reg_idx_t    ret_reg_addr;
    xlen_t       ret_wdata;
    reg_idx_t    rs1_addr;
    reg_idx_t    rs2_addr;
    xlen_t       rs1_data;
    xlen_t       rs2_data;
    logic        wb_cyc;
    logic        wb_stb;
    logic        wb_we;
    xlen_t       wb_adr;
    xlen_t       wb_dat_w;
    logic [3:0]  wb_sel;
    xlen_t       wb_dat_r;
    logic        wb_ack;
    logic        halted;

    // reference model of the register file and the counters.
    xlen_t       shadow_rf [`RETIRE_NREGS];
    count_t      model_instret;
    count_t      model_limit;
    logic        model_limit_en;
    logic        model_halted;
    logic [31:0] lfsr_state = 32'h5782_49d3;
    int          txn_count = 0;
    int          acks_seen = 0;

    retire_unit retire_unit_inst (
        .clk          (clk),
        .rst_n        (rst_n),
        .ret_valid    (ret_valid),
        .ret_pc       (ret_pc),
        .ret_inst     (ret_inst),
        .ret_inst_id  (ret_inst_id),
        .ret_rf_wen   (ret_rf_wen),
        .ret_reg_addr (ret_reg_addr),
        .ret_wdata    (ret_wdata),
        .rs1_addr     (rs1_addr),
        .rs2_addr     (rs2_addr),
        .rs1_data     (rs1_data),
        .rs2_data     (rs2_data),
        .wb_cyc       (wb_cyc),
        .wb_stb       (wb_stb),
        .wb_we        (wb_we),
        .wb_adr       (wb_adr),
        .wb_dat_w     (wb_dat_w),
        .wb_sel       (wb_sel),
        .wb_dat_r     (wb_dat_r),
        .wb_ack       (wb_ack),
        .halted       (halted)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // helpers.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    task automatic abort_run();
        $display("Simulation FAILED");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        assert (got === exp) else begin
            $display("[ERROR] %s: got %h, expected %h", name, got, exp);
            abort_run();
        end
    endtask

    // taps 32, 22, 2, 1.
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        logic        fb;
        r = '0;
        for (int i = 0; i < n; i++) begin
            fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
            lfsr_state = {lfsr_state[30:0], fb};
            r = {r[30:0], fb};
        end
        return r;
    endfunction

    function automatic xlen_t expected_read(input reg_idx_t idx);
        xlen_t value;
        value = shadow_rf[idx];
        if (idx == '0) begin
            value = '0;
        end else if (ret_valid && !model_halted && ret_rf_wen && (idx == ret_reg_addr)) begin
            value = ret_wdata;
        end
        return value;
    endfunction

    task automatic bus_access(input logic we, input logic [31:0] adr,
                              input logic [31:0] wdat, output logic [31:0] rdat);
        int waited;
        waited = 0;
        @(posedge clk);
        wb_cyc   <= 1'b1;
        wb_stb   <= 1'b1;
        wb_we    <= we;
        wb_adr   <= adr;
        wb_dat_w <= wdat;
        @(negedge clk);
        while (!wb_ack) begin
            if (waited == ack_timeout) begin
                $display("no Wishbone ack within %0d cycles at address %h", ack_timeout, adr);
                abort_run();
            end
            waited++;
            @(negedge clk);
        end
        rdat = wb_dat_r;
        txn_count++;
        @(posedge clk);
        wb_cyc <= 1'b0;
        wb_stb <= 1'b0;
        wb_we  <= 1'b0;
    endtask

    task automatic read_csr(input logic [31:0] adr, output logic [31:0] data);
        bus_access(1'b0, adr, 32'd0, data);
    endtask

    task automatic write_csr(input logic [31:0] adr, input logic [31:0] dat);
        logic [31:0] ignored;
        bus_access(1'b1, adr, dat, ignored);
        // clear has landed by the time the bus cycle ends.
        if (adr == ctrl_adr) begin
            model_limit_en = dat[0];
            if (dat[1]) begin
                model_instret = '0;
                model_halted  = 1'b0;
            end
        end else if (adr == limit_lo_adr) begin
            model_limit[31:0] = dat;
        end else if (adr == limit_hi_adr) begin
            model_limit[63:32] = dat;
        end
    endtask

    task automatic read_pair(input logic [31:0] lo_adr, output count_t value);
        logic [31:0] lo;
        logic [31:0] hi;
        read_csr(lo_adr, lo);
        read_csr(lo_adr + 32'd4, hi);
        value = {hi, lo};
    endtask

    task automatic check_window();
        logic [31:0] rd;
        for (int n = 0; n < `RETIRE_NREGS; n++) begin
            read_csr(regs_adr + 32'(4 * n), rd);
            check_value($sformatf("x%0d window", n), rd, (n == 0) ? 32'd0 : shadow_rf[n]);
        end
    endtask

    task automatic retire_burst(input int cycles, input logic all_valid);
        logic [31:0] bits;
        logic [4:0]  rd;
        for (int i = 0; i < cycles; i++) begin
            @(posedge clk);
            bits = rand_bits(1);
            ret_valid <= bits[0] | all_valid;
            bits = rand_bits(1);
            ret_rf_wen <= bits[0];
            bits = rand_bits(5);
            rd = bits[4:0];
            ret_reg_addr <= rd;
            ret_wdata <= rand_bits(32);
            ret_pc <= ret_pc + 32'd4;
            ret_inst_id <= ret_inst_id + 8'd1;
            // half the time read the register being written, to hit the bypass.
            bits = rand_bits(1);
            if (bits[0]) begin
                rs1_addr <= rd;
            end else begin
                bits = rand_bits(5);
                rs1_addr <= bits[4:0];
            end
            bits = rand_bits(5);
            rs2_addr <= bits[4:0];
        end
        @(posedge clk);
        ret_valid  <= 1'b0;
        ret_rf_wen <= 1'b0;
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // reference model and checks.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // inputs settle after the rising edge, the commit lands on the next one.
    always @(negedge clk) begin
        if (!rst_n) begin
            shadow_rf[0] = '0;
            for (int i = 1; i < `RETIRE_NREGS; i++) begin
                shadow_rf[i] = `RETIRE_REG_RESET;
            end
            model_instret  = '0;
            model_limit    = '0;
            model_limit_en = 1'b0;
            model_halted   = 1'b0;
        end else begin
            check_value("halted", halted, model_halted);
            check_value("rs1_data", rs1_data, expected_read(rs1_addr));
            check_value("rs2_data", rs2_data, expected_read(rs2_addr));
            if (ret_valid && !model_halted) begin
                if (ret_rf_wen && (ret_reg_addr != '0)) begin
                    shadow_rf[ret_reg_addr] = ret_wdata;
                end
                model_instret = model_instret + 64'd1;
                if (model_limit_en && (model_instret == model_limit)) begin
                    model_halted = 1'b1;
                end
            end
            if (wb_ack) begin
                acks_seen++;
            end
        end
    end

    a_ack_one_cycle: assert property (
        @(posedge clk) disable iff (!rst_n)
        wb_ack |=> !wb_ack
    ) else begin
        $display("wb_ack stayed high for a second cycle");
        abort_run();
    end

    a_ack_needs_request: assert property (
        @(posedge clk) disable iff (!rst_n)
        $rose(wb_ack) |-> $past(wb_cyc && wb_stb)
    ) else begin
        $display("wb_ack rose without a bus request");
        abort_run();
    end

    a_x0_reads_zero: assert property (
        @(posedge clk) disable iff (!rst_n)
        rs1_addr == '0 |-> rs1_data == '0
    ) else begin
        $display("[ERROR] rs1_data: got %h at index 0, expected 00000000", rs1_data);
        abort_run();
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // stimulus.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    initial begin
        logic [31:0] rd;
        logic [31:0] first_cycle;
        count_t      pair;
        rst_n        = 1'b0;
        ret_valid    = 1'b0;
        ret_pc       = 32'h0000_1000;
        ret_inst     = 32'h0000_0013;
        ret_inst_id  = '0;
        ret_rf_wen   = 1'b0;
        ret_reg_addr = '0;
        ret_wdata    = '0;
        rs1_addr     = '0;
        rs2_addr     = '0;
        wb_cyc       = 1'b0;
        wb_stb       = 1'b0;
        wb_we        = 1'b0;
        wb_adr       = '0;
        wb_dat_w     = '0;
        wb_sel       = 4'hf;
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;

        check_window();
        read_pair(instret_lo_adr, pair);
        check_value("instret", pair, 64'd0);
        read_csr(status_adr, rd);
        check_value("status", rd, 32'd0);
        read_pair(limit_lo_adr, pair);
        check_value("limit", pair, 64'd0);
        read_csr(ctrl_adr, rd);
        check_value("ctrl", rd, 32'd0);

        retire_burst(200, 1'b0);
        check_window();
        read_pair(instret_lo_adr, pair);
        check_value("instret", pair, model_instret);
        read_csr(cycle_lo_adr, first_cycle);
        read_csr(cycle_lo_adr, rd);
        assert (rd > first_cycle) else begin
            $display("[ERROR] cycle_lo: got %h, expected above %h", rd, first_cycle);
            abort_run();
        end

        // stop after a fixed number of retires.
        write_csr(ctrl_adr, 32'h2);
        write_csr(limit_lo_adr, halt_limit);
        write_csr(limit_hi_adr, 32'd0);
        write_csr(ctrl_adr, 32'h1);
        retire_burst(halt_limit + 10, 1'b1);
        check_value("halted", halted, 1'b1);
        read_csr(status_adr, rd);
        check_value("status", rd, 32'd1);
        read_pair(instret_lo_adr, pair);
        check_value("instret", pair, halt_limit);
        retire_burst(20, 1'b1);
        check_window();

        write_csr(ctrl_adr, 32'h2);
        read_csr(status_adr, rd);
        check_value("status", rd, 32'd0);
        read_pair(instret_lo_adr, pair);
        check_value("instret", pair, 64'd0);
        write_csr(status_adr, 32'h1);
        read_csr(status_adr, rd);
        check_value("status", rd, 32'd0);
        write_csr(regs_adr + 32'd20, 32'h1234_5678);
        check_window();
        read_csr(32'h0000_0040, rd);
        check_value("unmapped 0x40", rd, 32'd0);
        read_csr(32'h0000_1000, rd);
        check_value("unmapped 0x1000", rd, 32'd0);

        @(negedge clk);
        if (acks_seen != txn_count) begin
            $display("[ERROR] wb_ack count: got %h, expected %h", acks_seen, txn_count);
            abort_run();
        end else begin
            $display("Simulation PASSED");
            $finish;
        end
    end

endmodule

`default_nettype wire

/* all.f */
+incdir+rtl
rtl/retire_pkg.sv
rtl/retire_if.sv
rtl/write_back_stage.sv
rtl/retire_counters.sv
rtl/debug_csr.sv
rtl/retire_unit.sv
bench/tb_retire_unit.sv

/* Bender.yml */
package:
  name: retire_unit

sources:
  - target: any(rtl, test)
    include_dirs:
      - rtl
    files:
      - rtl/retire_pkg.sv
      - rtl/retire_if.sv
      - rtl/write_back_stage.sv
      - rtl/retire_counters.sv
      - rtl/debug_csr.sv
      - rtl/retire_unit.sv
  - target: test
    include_dirs:
      - rtl
    files:
      - bench/tb_retire_unit.sv
